// File: source/bank_htu_defs.svh
`ifndef BANK_HTU_DEFS_SVH
`define BANK_HTU_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BANK_HTU_WAYS 2
`define BANK_HTU_SETS 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag runs from bit 31 down to this bit.
`define BANK_HTU_TAG_LSB 10
// Set index sits just below the tag.
`define BANK_HTU_IDX_LSB 8
// Selects offset half 1 of the line.
`define BANK_HTU_OFS_BIT 7

`endif

// File: source/bank_htu_pkg.sv
package bank_htu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request opcodes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    OP_NONE       = 3'd0,
    OP_READ       = 3'd1,
    OP_WRITE      = 3'd2,
    OP_FLUSH      = 3'd3,
    OP_INVALIDATE = 3'd4
  } op_e;

  // Coherence state of one offset half.
  // Encoding 2'b11 is unused.
  typedef enum logic [1:0] {
    OFS_INVALID = 2'b00,
    OFS_CLEAN   = 2'b01,
    OFS_DIRTY   = 2'b10
  } ofs_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request and response.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
  } htu_req_s;

  typedef struct packed {
    logic       hit;
    logic       way;
    // State of the accessed half before the update.
    ofs_state_e ofs_state;
    logic       evict_dirty;
  } htu_rsp_s;

endpackage

// File: source/bank_htu_offset.sv
`timescale 1ns/1ps

module bank_htu_offset (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     offset_hit_i,
  input  bank_htu_pkg::op_e        op_i,
  input  logic                     line_hit_i,
  input  logic                     allocate_i,
  output bank_htu_pkg::ofs_state_e state_o
);

  bank_htu_pkg::ofs_state_e state_q;
  bank_htu_pkg::ofs_state_e state_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_d = state_q;
    if (allocate_i) begin
      // Only the accessed half is brought in on a refill.
      if (!offset_hit_i) begin
        state_d = bank_htu_pkg::OFS_INVALID;
      end else if (op_i == bank_htu_pkg::OP_WRITE) begin
        state_d = bank_htu_pkg::OFS_DIRTY;
      end else begin
        state_d = bank_htu_pkg::OFS_CLEAN;
      end
    end else if (line_hit_i) begin
      case (op_i)
        bank_htu_pkg::OP_READ: begin
          // Fill a missing half.
          if (offset_hit_i && (state_q == bank_htu_pkg::OFS_INVALID)) begin
            state_d = bank_htu_pkg::OFS_CLEAN;
          end
        end
        bank_htu_pkg::OP_WRITE: begin
          if (offset_hit_i) begin
            state_d = bank_htu_pkg::OFS_DIRTY;
          end
        end
        bank_htu_pkg::OP_FLUSH: begin
          // Both halves are written back.
          if (state_q == bank_htu_pkg::OFS_DIRTY) begin
            state_d = bank_htu_pkg::OFS_CLEAN;
          end
        end
        bank_htu_pkg::OP_INVALIDATE: begin
          state_d = bank_htu_pkg::OFS_INVALID;
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= bank_htu_pkg::OFS_INVALID;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // Reserved encoding must never be reached from any op sequence.
  a_state_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q != bank_htu_pkg::ofs_state_e'(2'b11));

endmodule

// File: source/bank_htu_cacheline.sv
`timescale 1ns/1ps

`include "bank_htu_defs.svh"

module bank_htu_cacheline (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             update_i,
  input  bank_htu_pkg::op_e                op_i,
  input  logic                             offset1_i,
  input  logic [31:`BANK_HTU_TAG_LSB]      tag_i,
  input  logic                             allocate_i,
  output logic                             hit_o,
  output bank_htu_pkg::ofs_state_e         offset0_state_o,
  output bank_htu_pkg::ofs_state_e         offset1_state_o,
  output logic                             valid_o,
  output logic                             dirty_o
);

  logic                        valid_q;
  logic [31:`BANK_HTU_TAG_LSB] tag_q;
  logic                        line_hit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookup.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign hit_o    = valid_q && (tag_i == tag_q);
  assign line_hit = update_i && hit_o;

  assign valid_o = valid_q;
  assign dirty_o = valid_q &&
                   ((offset0_state_o == bank_htu_pkg::OFS_DIRTY) ||
                    (offset1_state_o == bank_htu_pkg::OFS_DIRTY));

  // Valid bit.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (allocate_i) begin
      valid_q <= 1'b1;
    end else if (line_hit && (op_i == bank_htu_pkg::OP_INVALIDATE)) begin
      valid_q <= 1'b0;
    end
  end

  // Tag, loaded on refill.
  always_ff @(posedge clk_i) begin
    if (allocate_i) begin
      tag_q <= tag_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Offset halves.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  bank_htu_offset i_offset0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .offset_hit_i (!offset1_i),
    .op_i         (op_i),
    .line_hit_i   (line_hit),
    .allocate_i   (allocate_i),
    .state_o      (offset0_state_o)
  );

  bank_htu_offset i_offset1 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .offset_hit_i (offset1_i),
    .op_i         (op_i),
    .line_hit_i   (line_hit),
    .allocate_i   (allocate_i),
    .state_o      (offset1_state_o)
  );

  // The set only allocates on a miss, so a refill never meets a hit here.
  a_alloc_not_hit: assert property (@(posedge clk_i) disable iff (rst_i)
    !(allocate_i && line_hit));

endmodule

// File: source/bank_htu_set.sv
`timescale 1ns/1ps

`include "bank_htu_defs.svh"

module bank_htu_set (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     sel_i,
  input  bank_htu_pkg::htu_req_s   req_i,
  output logic                     hit_o,
  output logic                     way_o,
  output bank_htu_pkg::ofs_state_e ofs_state_o,
  output logic                     evict_dirty_o
);

  localparam int WAYS = `BANK_HTU_WAYS;

  logic                     update;
  logic                     alloc_op;
  logic                     alloc_miss;
  logic                     offset1;
  logic [WAYS-1:0]          way_hit;
  logic [WAYS-1:0]          way_valid;
  logic [WAYS-1:0]          way_dirty;
  logic [WAYS-1:0]          allocate;
  bank_htu_pkg::ofs_state_e off0_state [WAYS];
  bank_htu_pkg::ofs_state_e off1_state [WAYS];
  logic                     hit_way;
  logic                     inv_found;
  logic                     inv_way;
  logic                     victim;
  logic                     rr_q;

  // A set only updates when picked by the index and carrying an op.
  assign update   = sel_i && (req_i.op != bank_htu_pkg::OP_NONE);
  assign alloc_op = (req_i.op == bank_htu_pkg::OP_READ) ||
                    (req_i.op == bank_htu_pkg::OP_WRITE);
  assign offset1  = req_i.addr[`BANK_HTU_OFS_BIT];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ways.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    bank_htu_cacheline i_cacheline (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .update_i        (update),
      .op_i            (req_i.op),
      .offset1_i       (offset1),
      .tag_i           (req_i.addr[31:`BANK_HTU_TAG_LSB]),
      .allocate_i      (allocate[w]),
      .hit_o           (way_hit[w]),
      .offset0_state_o (off0_state[w]),
      .offset1_state_o (off1_state[w]),
      .valid_o         (way_valid[w]),
      .dirty_o         (way_dirty[w])
    );
  end

  // Hit combining and victim search.
  always_comb begin
    hit_way   = 1'b0;
    inv_found = 1'b0;
    inv_way   = 1'b0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way = 1'(w);
      end
      // Scanning downward leaves the lowest invalid way.
      if (!way_valid[w]) begin
        inv_found = 1'b1;
        inv_way   = 1'(w);
      end
    end
  end

  assign victim     = inv_found ? inv_way : rr_q;
  assign hit_o      = |way_hit;
  assign alloc_miss = update && alloc_op && !hit_o;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      allocate[w] = alloc_miss && (victim == 1'(w));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign way_o         = hit_o ? hit_way : victim;
  assign ofs_state_o   = offset1 ? off1_state[hit_way] : off0_state[hit_way];
  assign evict_dirty_o = alloc_miss && way_dirty[victim];

  // Round-robin pointer moves only when it picked the victim.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_q <= 1'b0;
    end else if (alloc_miss && !inv_found) begin
      rr_q <= !rr_q;
    end
  end

  // A tag lives in at most one way of the set.
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(way_hit));

endmodule

// File: source/bank_htu.sv
`timescale 1ns/1ps

`include "bank_htu_defs.svh"

module bank_htu (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_valid_i,
  input  bank_htu_pkg::htu_req_s req_i,
  output logic                   rsp_valid_o,
  output bank_htu_pkg::htu_rsp_s rsp_o
);

  localparam int SETS  = `BANK_HTU_SETS;
  localparam int IDX_W = $clog2(SETS);

  logic [IDX_W-1:0]         idx;
  logic [SETS-1:0]          set_sel;
  logic [SETS-1:0]          set_hit;
  logic [SETS-1:0]          set_way;
  logic [SETS-1:0]          set_evict;
  bank_htu_pkg::ofs_state_e set_state [SETS];
  bank_htu_pkg::htu_rsp_s   rsp_d;
  logic                     rsp_valid_q;
  bank_htu_pkg::htu_rsp_s   rsp_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Index decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign idx = req_i.addr[`BANK_HTU_IDX_LSB +: IDX_W];

  always_comb begin
    for (int s = 0; s < SETS; s++) begin
      set_sel[s] = req_valid_i && (idx == IDX_W'(s));
    end
  end

  for (genvar s = 0; s < SETS; s++) begin : g_set
    bank_htu_set i_set (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .sel_i         (set_sel[s]),
      .req_i         (req_i),
      .hit_o         (set_hit[s]),
      .way_o         (set_way[s]),
      .ofs_state_o   (set_state[s]),
      .evict_dirty_o (set_evict[s])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rsp_d.hit         = set_hit[idx];
    rsp_d.way         = set_way[idx];
    // A miss has no prior half state to report.
    rsp_d.ofs_state   = set_hit[idx] ? set_state[idx] : bank_htu_pkg::OFS_INVALID;
    rsp_d.evict_dirty = set_evict[idx];
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // Captured at the same edge as the state update.
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: test/bank_htu_tb.sv
`timescale 1ns/1ps

module bank_htu_tb;

  localparam int MAX_VECTORS = 64;
  localparam int FIELDS      = 6;
  localparam int RSP_TIMEOUT = 4;
  localparam int END_OP      = 7;

  logic                   clk_i;
  logic                   rst_i;
  logic                   req_valid_i;
  bank_htu_pkg::htu_req_s req_i;
  logic                   rsp_valid_o;
  bank_htu_pkg::htu_rsp_s rsp_o;

  logic [31:0] vec_mem [MAX_VECTORS * FIELDS];
  int          error_count;
  int          timeout_count;

  bank_htu i_bank_htu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  always #20 clk_i = !clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s expected %0b, got %0b",
               $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_state(input string name,
                             input bank_htu_pkg::ofs_state_e expected,
                             input bank_htu_pkg::ofs_state_e actual);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s expected %s (%0d), got %s (%0d)",
               $time, name, expected.name(), expected, actual.name(), actual);
      error_count++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request and response.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Called on a falling edge.
  task automatic send_request(input bank_htu_pkg::op_e op, input logic [31:0] addr);
    req_valid_i = 1'b1;
    req_i.op    = op;
    req_i.addr  = addr;
  endtask

  // Latency 0 means no response within the timeout.
  task automatic wait_response(output int latency);
    int cycles;
    latency = 0;
    cycles  = 0;
    while ((latency == 0) && (cycles < RSP_TIMEOUT)) begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
      cycles++;
      if (rsp_valid_o === 1'b1) begin
        latency = cycles;
      end
    end
  endtask

  task automatic apply_vector(input int index);
    int                       base;
    int                       latency;
    bank_htu_pkg::op_e        op;
    logic [31:0]              addr;
    bank_htu_pkg::ofs_state_e exp_state;
    base      = index * FIELDS;
    op        = bank_htu_pkg::op_e'(vec_mem[base][2:0]);
    addr      = vec_mem[base + 1];
    exp_state = bank_htu_pkg::ofs_state_e'(vec_mem[base + 4][1:0]);
    send_request(op, addr);
    wait_response(latency);
    if (latency == 0) begin
      $display("Timeout: no response to vector %0d (op %0d, address %08h) within %0d cycles",
               index, op, addr, RSP_TIMEOUT);
      timeout_count++;
    end else begin
      if (latency != 1) begin
        $display("Vector %0d got its response after %0d cycles instead of 1",
                 index, latency);
        error_count++;
      end
      check_bit("rsp_o.hit", vec_mem[base + 2][0], rsp_o.hit);
      check_bit("rsp_o.way", vec_mem[base + 3][0], rsp_o.way);
      check_state("rsp_o.ofs_state", exp_state, rsp_o.ofs_state);
      check_bit("rsp_o.evict_dirty", vec_mem[base + 5][0], rsp_o.evict_dirty);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int vec_count;
    bit found_end;
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    req_valid_i   = 1'b0;
    req_i.op      = bank_htu_pkg::OP_NONE;
    req_i.addr    = 32'h0;
    error_count   = 0;
    timeout_count = 0;
    vec_count     = 0;
    found_end     = 1'b0;

    $readmemh("test/bank_htu_vectors.txt", vec_mem);

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_bit("rsp_valid_o", 1'b0, rsp_valid_o);

    // Each vector is sent on the edge where the previous response was checked.
    @(negedge clk_i);
    while (!found_end && (vec_count < MAX_VECTORS)) begin
      if (vec_mem[vec_count * FIELDS] == 32'(END_OP)) begin
        found_end = 1'b1;
      end else begin
        apply_vector(vec_count);
        vec_count++;
      end
    end

    if (!found_end) begin
      $display("Vector file has no end marker within %0d vectors", MAX_VECTORS);
      error_count++;
    end
    if (vec_count == 0) begin
      $display("No vectors were loaded");
      error_count++;
    end

    // Response pulse must not stretch into an idle cycle.
    @(negedge clk_i);
    check_bit("rsp_valid_o", 1'b0, rsp_valid_o);

    $display("Vectors: %0d, mismatches: %0d, timeouts: %0d",
             vec_count, error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: bank_htu.f
+incdir+source
source/bank_htu_pkg.sv
source/bank_htu_offset.sv
source/bank_htu_cacheline.sv
source/bank_htu_set.sv
source/bank_htu.sv
test/bank_htu_tb.sv

// File: run_bank_htu.sh
#!/usr/bin/env bash
# Builds the bank_htu testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module bank_htu_tb \
  -f bank_htu.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/Vbank_htu_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test completed successfully" <<< "$sim_out"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: test/bank_htu_vectors.txt
// Columns (hex): op addr exp_hit exp_way exp_ofs_state exp_evict_dirty
// op 1 read 2 write 3 flush 4 invalidate 7 end; ofs_state 0 invalid 1 clean 2 dirty
// Cold read in set 0 misses into way 0, the repeat hits clean.
1 00000000 0 0 0 0
1 00000000 1 0 1 0
// Write miss in set 1, then reads of the other half.
2 00000500 0 0 0 0
1 00000580 1 0 0 0
1 00000580 1 0 1 0
// Write hit on a clean half, flush, read.
2 00000000 1 0 1 0
3 00000000 1 0 2 0
1 00000000 1 0 1 0
// Second tag in set 1 takes way 1, then way 0 is invalidated and refilled.
1 00000900 0 1 0 0
4 00000500 1 0 2 0
1 00000500 0 0 0 0
1 00000900 1 1 1 0
// Set 2 fills both ways, the third tag evicts dirty way 0.
2 00000200 0 0 0 0
1 00000600 0 1 0 0
1 00000a00 0 0 0 1
// Set 0 is untouched by set 2 traffic.
1 00000000 1 0 1 0
// Pointer now names way 1, then way 0 again.
1 00000e00 0 1 0 0
1 00000200 0 0 0 0
// Write hit on an invalid half, then a dirty eviction from way 1.
2 00000e80 1 1 0 0
1 00000a00 0 1 0 1
// Back-to-back requests on one line in set 3.
2 00000380 0 0 0 0
1 00000380 1 0 2 0
1 00000300 1 0 0 0
1 00000300 1 0 1 0
3 00000380 1 0 2 0
1 00000380 1 0 1 0
// End of vectors.
7 00000000 0 0 0 0
